//--- fma16.sv
`timescale 1ns/1ns

module fma16 (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          valid_in,
    input  logic [fma_pkg::width-1:0]     x,
    input  logic [fma_pkg::width-1:0]     y,
    input  logic [fma_pkg::width-1:0]     z,
    input  logic                          mul,        // 0 -> y taken as 1.0
    input  logic                          add,        // 0 -> z taken as +0
    input  logic                          negp,       // negate the product
    input  logic                          negz,       // negate the addend
    input  fma_pkg::round_e               roundmode,
    output logic                          valid_out,
    output logic [fma_pkg::width-1:0]     result,
    output logic [fma_pkg::flag_bits-1:0] flags       // {nv, of, uf, nx}
);

    ////////////////////
    // stage 1 unpack
    ////////////////////

    logic [fma_pkg::width-1:0]    yv, zv;
    logic                         xs, ys, zs;
    logic [fma_pkg::exp_bits-1:0] xe, ye, ze;
    logic [fma_pkg::man_bits-1:0] xm, ym, zm;
    logic                         x_zero, y_zero, z_zero;
    logic                         x_inf, y_inf, z_inf;
    logic                         x_nan, y_nan, z_nan;

    assign yv = mul ? y : fma_pkg::one_val;
    assign zv = add ? z : '0;

    assign {xs, xe, xm} = x;
    assign {ys, ye, ym} = yv;
    assign {zs, ze, zm} = zv;

    // subnormals have a zero exponent too, so they land here as zero
    assign x_zero = (xe == '0);
    assign y_zero = (ye == '0);
    assign z_zero = (ze == '0);
    assign x_inf  = (xe == '1) && (xm == '0);
    assign y_inf  = (ye == '1) && (ym == '0);
    assign z_inf  = (ze == '1) && (zm == '0);
    assign x_nan  = (xe == '1) && (xm != '0);
    assign y_nan  = (ye == '1) && (ym != '0);
    assign z_nan  = (ze == '1) && (zm != '0);

    ////////////////////
    // product and align
    ////////////////////

    logic [10:0]       xf, yf, zf;   // significands with hidden one
    logic [21:0]       pm;           // exact 11x11 product
    logic              prod_zero;
    logic signed [7:0] pe;           // biased product exponent
    logic signed [7:0] a_cnt;        // pe - ze
    logic signed [7:0] sh;
    logic [6:0]        sh_amt;
    logic [98:0]       zwide;
    logic [66:0]       z_al;         // addend in the sum field, bit 0 sticky

    assign xf = x_zero ? 11'd0 : {1'b1, xm};
    assign yf = y_zero ? 11'd0 : {1'b1, ym};
    assign zf = z_zero ? 11'd0 : {1'b1, zm};
    assign pm = xf * yf;

    assign prod_zero = x_zero | y_zero;
    // with no product, pin pe to ze so the addend sits at its natural spot
    assign pe = prod_zero ? {3'b000, ze}
                          : {3'b000, xe} + {3'b000, ye} - 8'(fma_pkg::bias);

    // field bit k weighs 2^(pe-38+k), product lsb at bit 3
    assign a_cnt  = pe - {3'b000, ze};
    assign sh     = a_cnt + 8'sd43;             // addend lsb lands at 56 - sh
    assign sh_amt = sh[7] ? 7'd0 : sh[6:0];     // negative only with inf/nan exponents
    assign zwide  = {zf, 88'd0} >> sh_amt;
    assign z_al   = {zwide[98:33], |zwide[32:0]};  // anything under bit 1 goes sticky

    ////////////////////
    // stage 1 register
    ////////////////////

    logic              s1_valid;
    logic [21:0]       s1_pm;
    logic [66:0]       s1_al;
    logic signed [7:0] s1_pe;
    logic              s1_ps, s1_zs;
    logic              s1_nan, s1_inv, s1_pinf, s1_zinf;
    fma_pkg::round_e   s1_rm;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            s1_pm   <= pm;
            s1_al   <= z_al;
            s1_pe   <= pe;
            s1_ps   <= xs ^ ys ^ negp;                          // effective product sign
            s1_zs   <= zs ^ negz;                               // effective addend sign
            s1_nan  <= x_nan | y_nan | z_nan;
            s1_inv  <= (x_inf & y_zero) | (y_inf & x_zero);     // inf * 0
            s1_pinf <= x_inf | y_inf;
            s1_zinf <= z_inf;
            s1_rm   <= roundmode;
        end
    end

    ////////////////////
    // stage 2 sum
    ////////////////////

    logic [67:0] pf, af, mag;
    logic        sgn;

    assign pf = {43'd0, s1_pm, 3'b000};
    assign af = {1'b0, s1_al};

    always_comb begin
        if (s1_ps == s1_zs) begin
            mag = pf + af;         // same signs, magnitudes add
            sgn = s1_ps;
        end else if (pf >= af) begin
            mag = pf - af;
            sgn = s1_ps;
        end else begin
            mag = af - pf;         // addend wins the sign
            sgn = s1_zs;
        end
    end

    ////////////////////
    // normalize and round
    ////////////////////

    logic [6:0]        lead;       // leading one position
    logic [67:0]       norm;
    logic              guard, sticky, rnd_up, ovf_inf, zero_sgn;
    logic [11:0]       sig_r;
    logic signed [9:0] e_pre, e_rnd;

    // priority encoder, highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < 68; i++) begin
            if (mag[i]) begin
                lead = 7'(i);
            end
        end
    end

    assign norm   = mag << (7'd67 - lead);          // leading one to bit 67
    assign guard  = norm[56];
    assign sticky = |norm[55:0];
    assign e_pre  = {{2{s1_pe[7]}}, s1_pe} + {3'b000, lead} - 10'd23;

    always_comb begin
        case (s1_rm)
            fma_pkg::rnd_rz:  rnd_up = 1'b0;
            fma_pkg::rnd_rne: rnd_up = guard & (sticky | norm[57]);  // ties to even
            fma_pkg::rnd_rdn: rnd_up = sgn & (guard | sticky);
            default:          rnd_up = ~sgn & (guard | sticky);
        endcase
    end

    assign sig_r = {1'b0, norm[67:57]} + {11'd0, rnd_up};
    assign e_rnd = e_pre + {9'd0, sig_r[11]};  // mantissa carry bumps the exponent

    // overflow goes to inf unless the mode rounds toward the finite side
    assign ovf_inf  = (s1_rm == fma_pkg::rnd_rne)
                    | ((s1_rm == fma_pkg::rnd_rdn) & sgn)
                    | ((s1_rm == fma_pkg::rnd_rup) & ~sgn);
    // exact zero keeps a shared sign, else -0 only when rounding down
    assign zero_sgn = (s1_ps == s1_zs) ? s1_ps : (s1_rm == fma_pkg::rnd_rdn);

    ////////////////////
    // result select
    ////////////////////

    logic [fma_pkg::width-1:0]     res_d;
    logic [fma_pkg::flag_bits-1:0] flg_d;

    always_comb begin
        flg_d = '0;
        if (s1_nan) begin
            res_d = fma_pkg::nan_val;                 // quiet, no invalid
        end else if (s1_inv || (s1_pinf && s1_zinf && (s1_ps != s1_zs))) begin
            res_d    = fma_pkg::nan_val;              // inf*0 or inf-inf
            flg_d[3] = 1'b1;
        end else if (s1_pinf) begin
            res_d = {s1_ps, fma_pkg::inf_val[14:0]};
        end else if (s1_zinf) begin
            res_d = {s1_zs, fma_pkg::inf_val[14:0]};
        end else if (mag == '0) begin
            res_d = {zero_sgn, 15'd0};
        end else if (e_rnd > 10'sd30) begin
            res_d = ovf_inf ? {sgn, fma_pkg::inf_val[14:0]} : {sgn, fma_pkg::max_val[14:0]};
            flg_d = 4'b0101;                          // overflow + inexact
        end else if (e_rnd < 10'sd1) begin
            res_d = {sgn, 15'd0};                     // flush to zero
            flg_d = 4'b0011;                          // underflow + inexact
        end else begin
            res_d    = {sgn, e_rnd[4:0], sig_r[9:0]};
            flg_d[0] = guard | sticky;
        end
    end

    ////////////////////
    // stage 2 register
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            result <= res_d;
            flags  <= flg_d;
        end
    end

endmodule

//--- fma16_array.sv
`timescale 1ns/1ns

module fma16_array (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         start,
    input  fma_pkg::fma_op_e                             op,
    input  fma_pkg::round_e                              roundmode,
    input  logic [fma_pkg::lanes*fma_pkg::width-1:0]     x,
    input  logic [fma_pkg::lanes*fma_pkg::width-1:0]     y,
    input  logic [fma_pkg::lanes*fma_pkg::width-1:0]     z,
    input  logic                                         clear_flags,
    output logic                                         done,
    output logic [fma_pkg::lanes*fma_pkg::width-1:0]     result,
    output logic [fma_pkg::lanes*fma_pkg::flag_bits-1:0] lane_flags,
    output logic [fma_pkg::flag_bits-1:0]                sticky_flags
);

    logic                                         issue_valid;
    logic [fma_pkg::lanes*fma_pkg::width-1:0]     x_q, y_q, z_q;
    fma_pkg::round_e                              round_q;
    logic                                         mul, add, negp, negz;  // shared lane controls
    logic [fma_pkg::lanes-1:0]                    lane_valid;            // identical per lane
    logic [fma_pkg::lanes*fma_pkg::width-1:0]     result_bus;
    logic [fma_pkg::lanes*fma_pkg::flag_bits-1:0] flags_bus;

    fma_issue u_issue (
        .clk, .reset, .start, .op, .roundmode, .x, .y, .z,
        .issue_valid, .x_q, .y_q, .z_q, .round_q, .mul, .add, .negp, .negz
    );

    ////////////////////
    // lanes
    ////////////////////

    for (genvar i = 0; i < fma_pkg::lanes; i++) begin : g_lane
        fma16 u_fma16 (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (issue_valid),
            .x         (x_q[i*fma_pkg::width +: fma_pkg::width]),
            .y         (y_q[i*fma_pkg::width +: fma_pkg::width]),
            .z         (z_q[i*fma_pkg::width +: fma_pkg::width]),
            .mul       (mul),
            .add       (add),
            .negp      (negp),
            .negz      (negz),
            .roundmode (round_q),
            .valid_out (lane_valid[i]),
            .result    (result_bus[i*fma_pkg::width +: fma_pkg::width]),
            .flags     (flags_bus[i*fma_pkg::flag_bits +: fma_pkg::flag_bits])
        );
    end

    fma_collect u_collect (
        .clk, .reset,
        .valid (lane_valid[0]),   // lanes run in lockstep
        .result_bus, .flags_bus, .clear_flags,
        .done, .result, .lane_flags, .sticky_flags
    );

endmodule

//--- fma16_array_properties.sv
`timescale 1ns/1ns

module fma16_array_properties (
    input logic                                         clk,
    input logic                                         reset,
    input logic                                         start,
    input logic                                         done,
    input logic                                         clear_flags,
    input logic [fma_pkg::flag_bits-1:0]                sticky_flags,
    input logic [fma_pkg::lanes*fma_pkg::width-1:0]     result,
    input logic [fma_pkg::lanes*fma_pkg::flag_bits-1:0] lane_flags
);

    ////////////////////
    // timing
    ////////////////////

    // fixed pipeline, no stalls
    a_done_after_start : assert property (@(posedge clk) disable iff (reset)
        start |-> ##(fma_pkg::latency) done)
        else $error("done missing latency cycles after start");

    a_no_stray_done : assert property (@(posedge clk) disable iff (reset)
        done |-> $past(start, fma_pkg::latency))
        else $error("done without a matching start");

    ////////////////////
    // flags
    ////////////////////

    a_sticky_grows : assert property (@(posedge clk) disable iff (reset)
        (!$past(clear_flags) && !$past(reset)) |->
            ((sticky_flags | $past(sticky_flags)) == sticky_flags))
        else $error("sticky flags lost a bit without clear");

    a_known_outputs : assert property (@(posedge clk) disable iff (reset)
        !$isunknown({done, result, lane_flags, sticky_flags}))  // all reset in collect
        else $error("unknown value on an output");

endmodule

//--- fma16_model.svh
`ifndef FMA16_MODEL_SVH
`define FMA16_MODEL_SVH

function automatic logic is_nan(input logic [15:0] h);
    return (h[14:10] == 5'h1f) && (h[9:0] != 10'd0);
endfunction

function automatic logic is_inf(input logic [15:0] h);
    return (h[14:10] == 5'h1f) && (h[9:0] == 10'd0);
endfunction

// zero exponent covers subnormals too, they count as zero
function automatic logic is_zero(input logic [15:0] h);
    return h[14:10] == 5'd0;
endfunction

function automatic logic [127:0] signif(input logic [15:0] h);
    return {117'd0, 1'b1, h[9:0]};
endfunction

// exact reference, values held as integers in units of 2^-48
// returns {flags, result}
function automatic logic [19:0] fma_ref(input logic [15:0] x, y, z,
                                        input fma_pkg::fma_op_e op,
                                        input fma_pkg::round_e rm);
    logic [15:0]  yy, zz;
    logic         ps, zs, sgn, up;
    logic [127:0] pmag, zmag, mag, sig, rem, half;
    int           lead, e;
    yy = (op == fma_pkg::op_add) ? 16'h3c00 : y;     // x + z means y = 1.0
    zz = (op == fma_pkg::op_mul) ? 16'h0000 : z;     // product only
    ps = x[15] ^ yy[15] ^ (op == fma_pkg::op_fnma);
    zs = zz[15] ^ (op == fma_pkg::op_fms);
    ////////////////////
    // special operands
    ////////////////////
    if (is_nan(x) || is_nan(yy) || is_nan(zz))
        return {4'b0000, fma_pkg::nan_val};
    if ((is_inf(x) && is_zero(yy)) || (is_inf(yy) && is_zero(x)))
        return {4'b1000, fma_pkg::nan_val};
    if ((is_inf(x) || is_inf(yy)) && is_inf(zz) && (ps != zs))
        return {4'b1000, fma_pkg::nan_val};
    if (is_inf(x) || is_inf(yy))
        return {4'b0000, ps, 15'h7c00};
    if (is_inf(zz))
        return {4'b0000, zs, 15'h7c00};
    ////////////////////
    // exact sum
    ////////////////////
    pmag = (is_zero(x) || is_zero(yy)) ? 128'd0
         : (signif(x) * signif(yy)) << (int'(x[14:10]) + int'(yy[14:10]) - 2);
    zmag = is_zero(zz) ? 128'd0 : signif(zz) << (int'(zz[14:10]) + 23);
    if (ps == zs) begin
        mag = pmag + zmag;
        sgn = ps;
    end else if (pmag >= zmag) begin
        mag = pmag - zmag;
        sgn = ps;
    end else begin
        mag = zmag - pmag;
        sgn = zs;
    end
    if (mag == 128'd0)  // exact zero, -0 only for like signs or rounding down
        return {4'b0000, (ps == zs) ? ps : (rm == fma_pkg::rnd_rdn), 15'd0};
    ////////////////////
    // single rounding
    ////////////////////
    lead = 0;
    for (int i = 0; i < 128; i++) begin
        if (mag[i]) lead = i;
    end
    if (lead >= 10) begin
        sig  = mag >> (lead - 10);                   // 11 kept bits
        rem  = mag - (sig << (lead - 10));
        half = (lead > 10) ? (128'd1 << (lead - 11)) : 128'd0;
    end else begin
        sig  = mag << (10 - lead);
        rem  = 128'd0;
        half = 128'd0;
    end
    e = lead - 33;  // biased exponent, 2^48 is 1.0
    case (rm)
        fma_pkg::rnd_rz:  up = 1'b0;
        fma_pkg::rnd_rne: up = (rem != 0) && ((rem > half) || ((rem == half) && sig[0]));
        fma_pkg::rnd_rdn: up = sgn && (rem != 0);
        default:          up = !sgn && (rem != 0);
    endcase
    sig = sig + {127'd0, up};
    if (sig[11]) begin  // rounded up to 2.0
        sig = sig >> 1;
        e   = e + 1;
    end
    if (e > 30) begin
        if ((rm == fma_pkg::rnd_rne) || ((rm == fma_pkg::rnd_rdn) && sgn)
                || ((rm == fma_pkg::rnd_rup) && !sgn))
            return {4'b0101, sgn, 15'h7c00};
        return {4'b0101, sgn, 15'h7bff};
    end
    if (e < 1)
        return {4'b0011, sgn, 15'd0};  // below smallest normal, flushed
    return {3'b000, rem != 0, sgn, e[4:0], sig[9:0]};
endfunction

`endif

//--- fma16_array_tb.sv
`timescale 1ns/1ns

module fma16_array_tb;

    localparam int num_random   = 400;
    localparam int max_ops      = num_random + 16;
    localparam int reset_cycles = 4;
    // each op may trail one idle gap, plus slack for drains and clears
    localparam int timeout_ns = 2 * 8 * (2 * max_ops + fma_pkg::latency + reset_cycles + 64);

    logic             clk, reset, start, clear_flags, done;
    fma_pkg::fma_op_e op;
    fma_pkg::round_e  roundmode;
    logic [63:0]      x, y, z, result;
    logic [15:0]      lane_flags;
    logic [3:0]       sticky_flags;

    logic [63:0] exp_res[$];   // expected results, oldest first
    logic [15:0] exp_flg[$];
    logic [3:0]  sticky_exp;
    int          errors, n_started, n_done;

    `include "fma16_model.svh"

    fma16_array dut (
        .clk, .reset, .start, .op, .roundmode, .x, .y, .z, .clear_flags,
        .done, .result, .lane_flags, .sticky_flags
    );

    bind fma16_array fma16_array_properties u_props (
        .clk(clk), .reset(reset), .start(start), .done(done), .clear_flags(clear_flags),
        .sticky_flags(sticky_flags), .result(result), .lane_flags(lane_flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    task automatic check(input string what, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s got %h, expected %h", $time, what, got, want);
        end
    endtask

    function automatic logic [63:0] pack4(input logic [15:0] a, b, c, d);
        return {d, c, b, a};  // lane 0 in the low word
    endfunction

    // mostly mid-range normals, some specials and exponent extremes
    function automatic logic [15:0] rand_word();
        logic [31:0] r;
        int          kind;
        r    = $urandom;
        kind = $urandom % 20;
        if (kind < 14) return {r[15], 5'(8 + $urandom % 15), r[9:0]};
        if (kind < 17) begin
            case ($urandom % 3)
                0:       return {r[15], 5'd0, r[9:0]};              // zero or subnormal
                1:       return {r[15], 5'h1f, 10'd0};              // infinity
                default: return {r[15], 5'h1f, r[9:0] | 10'h200};  // nan
            endcase
        end
        if (r[16]) return {r[15], 5'(1 + $urandom % 3), r[9:0]};
        return {r[15], 5'(27 + $urandom % 4), r[9:0]};
    endfunction

    task automatic issue_op(input fma_pkg::fma_op_e o, input fma_pkg::round_e rm,
                            input logic [63:0] xv, yv, zv);
        logic [63:0] r;
        logic [15:0] f;
        logic [19:0] m;
        @(negedge clk);
        start     = 1'b1;
        op        = o;
        roundmode = rm;
        x         = xv;
        y         = yv;
        z         = zv;
        for (int i = 0; i < fma_pkg::lanes; i++) begin
            m = fma_ref(xv[i*16 +: 16], yv[i*16 +: 16], zv[i*16 +: 16], o, rm);
            r[i*16 +: 16] = m[15:0];
            f[i*4 +: 4]   = m[19:16];
        end
        exp_res.push_back(r);
        exp_flg.push_back(f);
        n_started++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            start = 1'b0;
        end
    endtask

    // wait for the pipe to drain, then pulse clear_flags
    task automatic clear_sticky();
        idle(1);
        wait (n_done == n_started);
        idle(2);
        @(negedge clk) clear_flags = 1'b1;
        @(negedge clk) clear_flags = 1'b0;
        sticky_exp = '0;
        check("sticky flags after clear", {12'd0, sticky_flags}, 16'd0);
    endtask

    ////////////////////
    // response monitor
    ////////////////////

    always @(negedge clk) begin : monitor
        logic [63:0] r;
        logic [15:0] f;
        if (!reset && done) begin
            if (exp_res.size() == 0) begin
                errors++;
                $display("done pulse arrived with no operation outstanding");
            end else begin
                r = exp_res.pop_front();
                f = exp_flg.pop_front();
                for (int i = 0; i < fma_pkg::lanes; i++) begin
                    check($sformatf("lane %0d result", i), result[i*16 +: 16], r[i*16 +: 16]);
                    check($sformatf("lane %0d flags", i), {12'd0, lane_flags[i*4 +: 4]},
                          {12'd0, f[i*4 +: 4]});
                end
                sticky_exp = sticky_exp | f[3:0] | f[7:4] | f[11:8] | f[15:12];
                check("sticky flags", {12'd0, sticky_flags}, {12'd0, sticky_exp});
            end
            n_done++;
        end
    end

    initial begin
        timeout_watch : begin
            #(timeout_ns);
            $display("watchdog expired before all results came back");
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        logic [63:0] xr;
        void'($urandom(43));
        reset = 1'b1;
        start = 1'b0;
        clear_flags = 1'b0;
        op = fma_pkg::op_fma;
        roundmode = fma_pkg::rnd_rne;
        x = '0;
        y = '0;
        z = '0;
        sticky_exp = '0;
        errors = 0;
        n_started = 0;
        n_done = 0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        // inf*0, nan in, inf-inf, subnormal product, all back to back
        issue_op(fma_pkg::op_fma, fma_pkg::rnd_rne, pack4(16'h7c00, 16'h7e00, 16'h7c00, 16'h0001),
                 pack4(16'h0000, 16'h3c00, 16'h3c00, 16'h3c00),
                 pack4(16'h3c00, 16'h3c00, 16'hfc00, 16'h0000));
        issue_op(fma_pkg::op_add, fma_pkg::rnd_rz, pack4(16'h7c00, 16'h3c00, 16'hfe00, 16'h0000),
                 {$urandom, $urandom}, pack4(16'hfc00, 16'hbc00, 16'h3c00, 16'h8000));
        for (int r = 0; r < 4; r++) begin
            xr = {rand_word(), rand_word(), rand_word(), rand_word()};
            issue_op(fma_pkg::op_fms, fma_pkg::round_e'(r), xr, {4{16'h3c00}}, xr);  // x*1-x
            issue_op(fma_pkg::op_add, fma_pkg::round_e'(r), xr, '0, xr ^ {4{16'h8000}});
            // both overflow signs, then both flush signs
            issue_op(fma_pkg::op_mul, fma_pkg::round_e'(r),
                     pack4(16'h7bff, 16'hfbff, 16'h0400, 16'h8400),
                     pack4(16'h7bff, 16'h7bff, 16'h0400, 16'h0400), '0);
        end
        clear_sticky();
        for (int n = 0; n < num_random; n++) begin
            issue_op(fma_pkg::fma_op_e'($urandom % 5), fma_pkg::round_e'($urandom % 4),
                     {rand_word(), rand_word(), rand_word(), rand_word()},
                     {rand_word(), rand_word(), rand_word(), rand_word()},
                     {rand_word(), rand_word(), rand_word(), rand_word()});
            if ($urandom % 4 == 0) idle(1);
            if (n == num_random / 2) clear_sticky();
        end
        idle(1);
        wait (n_done == n_started);
        idle(fma_pkg::latency + 2);
        check("done count", 16'(n_done), 16'(n_started));
        $display("errors: %0d, operations started: %0d, done: %0d", errors, n_started, n_done);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- fma_collect.sv
`timescale 1ns/1ns

module fma_collect (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         valid,        // lane 0 speaks for all
    input  logic [fma_pkg::lanes*fma_pkg::width-1:0]     result_bus,
    input  logic [fma_pkg::lanes*fma_pkg::flag_bits-1:0] flags_bus,
    input  logic                                         clear_flags,  // level
    output logic                                         done,
    output logic [fma_pkg::lanes*fma_pkg::width-1:0]     result,
    output logic [fma_pkg::lanes*fma_pkg::flag_bits-1:0] lane_flags,
    output logic [fma_pkg::flag_bits-1:0]                sticky_flags
);

    ////////////////////
    // flag reduction
    ////////////////////

    logic [fma_pkg::flag_bits-1:0] any_flags;

    always_comb begin
        any_flags = '0;
        for (int i = 0; i < fma_pkg::lanes; i++) begin
            any_flags = any_flags | flags_bus[i*fma_pkg::flag_bits +: fma_pkg::flag_bits];
        end
    end

    ////////////////////
    // output registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            done       <= 1'b0;
            result     <= '0;
            lane_flags <= '0;
        end else begin
            done <= valid;            // one pulse per op
            if (valid) begin
                result     <= result_bus;   // held until the next done
                lane_flags <= flags_bus;
            end
        end
    end

    // sticky accumulates with done, clear wins on the same edge
    always_ff @(posedge clk) begin
        if (reset || clear_flags) begin
            sticky_flags <= '0;
        end else if (valid) begin
            sticky_flags <= sticky_flags | any_flags;
        end
    end

endmodule

//--- fma_issue.sv
`timescale 1ns/1ns

module fma_issue (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     start,      // one op per strobe
    input  fma_pkg::fma_op_e                         op,
    input  fma_pkg::round_e                          roundmode,
    input  logic [fma_pkg::lanes*fma_pkg::width-1:0] x,
    input  logic [fma_pkg::lanes*fma_pkg::width-1:0] y,
    input  logic [fma_pkg::lanes*fma_pkg::width-1:0] z,
    output logic                                     issue_valid,
    output logic [fma_pkg::lanes*fma_pkg::width-1:0] x_q,
    output logic [fma_pkg::lanes*fma_pkg::width-1:0] y_q,
    output logic [fma_pkg::lanes*fma_pkg::width-1:0] z_q,
    output fma_pkg::round_e                          round_q,
    output logic                                     mul,
    output logic                                     add,
    output logic                                     negp,
    output logic                                     negz
);

    ////////////////////
    // opcode decode
    ////////////////////

    logic mul_d, add_d, negp_d, negz_d;

    always_comb begin
        mul_d  = (op != fma_pkg::op_add);   // add keeps x, y becomes 1.0
        add_d  = (op != fma_pkg::op_mul);   // mul drops the addend
        negp_d = (op == fma_pkg::op_fnma);  // flip the product sign
        negz_d = (op == fma_pkg::op_fms);   // flip the addend sign
    end

    ////////////////////
    // issue register
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= start;  // single cycle pulse, no stalls
        end
    end

    // operands and controls only move on a strobe
    always_ff @(posedge clk) begin
        if (start) begin
            x_q     <= x;
            y_q     <= y;
            z_q     <= z;
            round_q <= roundmode;
            mul     <= mul_d;
            add     <= add_d;
            negp    <= negp_d;
            negz    <= negz_d;
        end
    end

endmodule

//--- fma_pkg.sv
package fma_pkg;

    ////////////////////
    // lane layout
    ////////////////////

    localparam int lanes     = 4;    // fma16 lanes side by side
    localparam int width     = 16;   // one binary16 word
    localparam int exp_bits  = 5;    // exponent field
    localparam int man_bits  = 10;   // stored mantissa, hidden one not counted
    localparam int bias      = 15;   // exponent bias
    localparam int flag_bits = 4;    // {invalid, overflow, underflow, inexact}
    localparam int latency   = 4;    // start strobe to done pulse, in cycles

    ////////////////////
    // special encodings
    ////////////////////

    localparam logic [width-1:0] inf_val = 16'b0_11111_0000000000;  // +infinity
    localparam logic [width-1:0] nan_val = 16'b0_11111_0000000001;  // the one nan we emit
    localparam logic [width-1:0] max_val = 16'b0_11110_1111111111;  // largest finite
    localparam logic [width-1:0] one_val = 16'b0_01111_0000000000;  // +1.0

    // vector opcodes, decoded into mul/add/negp/negz by the issue stage
    typedef enum logic [2:0] {
        op_fma  = 3'd0,  // x*y + z
        op_fms  = 3'd1,  // x*y - z
        op_fnma = 3'd2,  // -x*y + z
        op_mul  = 3'd3,  // x*y, addend forced to +0
        op_add  = 3'd4   // x + z, multiplier forced to 1
    } fma_op_e;

    // rounding modes, same 2-bit code the lane has always taken
    typedef enum logic [1:0] {
        rnd_rz  = 2'd0,  // toward zero
        rnd_rne = 2'd1,  // nearest, ties to even
        rnd_rdn = 2'd2,  // toward -inf
        rnd_rup = 2'd3   // toward +inf
    } round_e;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fma16_array_tb \
    -f src.f -o fma16_sim

status=0
./obj_dir/fma16_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- src.f
+incdir+.
fma_pkg.sv
fma_issue.sv
fma16.sv
fma_collect.sv
fma16_array.sv
fma16_array_properties.sv
fma16_array_tb.sv
